/* Bender.yml */
package:
  name: dma_subsystem

sources:
  - design/dma_pkg.sv
  - design/sync_fifo.sv
  - design/dma.sv
  - design/ddr_user_port.sv
  - design/dma_subsystem.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/dma_tb.sv

/* bench/dma_tb_tasks.svh */
`ifndef DMA_TB_TASKS_SVH
`define DMA_TB_TASKS_SVH

task automatic report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
	$display("Error at %0t: %s expected 0x%08h, actual 0x%08h", $time, sig, exp, act);
	err_count++;
endtask

task automatic report_problem(input string what);
	$display("At time %0t the %s", $time, what);
	err_count++;
endtask

task automatic report_test(input string name, input int errs_before);
	if (err_count == errs_before) begin
		pass_count++;
		$display("%s: passed", name);
	end else begin
		fail_count++;
		$display("%s: failed with %0d errors", name, err_count - errs_before);
	end
endtask

// One random word per cycle into the input buffer
task automatic push_words(input int n);
	for (int i = 0; i < n; i++) begin
		@(negedge clk);
		in_push = 1'b1;
		in_data = $random(seed);
		exp_q.push_back(in_data);
	end
	@(negedge clk);
	in_push = 1'b0;
endtask

task automatic wait_in_empty(input int limit);
	int cycles;
	cycles = 0;
	while (in_count != 0 && cycles < limit) begin
		@(negedge clk);
		cycles++;
	end
	if (in_count != 0) begin
		report_problem("input buffer did not drain to memory");
	end
endtask

task automatic wait_out_level(input int level, input int limit);
	int cycles;
	cycles = 0;
	while (out_count < level && cycles < limit) begin
		@(negedge clk);
		cycles++;
	end
	if (out_count < level) begin
		report_problem($sformatf("output buffer never reached %0d words", level));
	end
endtask

// Read mode stays on until the last burst has begun
task automatic read_bursts(input int n);
	int base;
	base = out_count;
	@(negedge clk);
	reads_en = 1'b1;
	wait_out_level(base + (n - 1) * BURST_LEN + 1, 100 * n + 100);
	reads_en = 1'b0;
	wait_out_level(base + n * BURST_LEN, 200);
	repeat (20) @(negedge clk);
	if (out_count != base + n * BURST_LEN) begin
		report_mismatch("out_count", base + n * BURST_LEN, out_count);
	end
endtask

task automatic pop_check(input int n);
	logic [31:0] exp;
	for (int i = 0; i < n; i++) begin
		@(negedge clk);
		out_pop = 1'b1;
		@(negedge clk);
		out_pop = 1'b0;
		if (exp_q.size() == 0) begin
			report_problem("output buffer returned a word that was never written");
		end else begin
			exp = exp_q.pop_front();
			if (out_valid !== 1'b1) begin
				report_mismatch("out_valid", 1, out_valid);
			end else if (out_data !== exp) begin
				report_mismatch("out_data", exp, out_data);
			end
		end
	end
endtask

task automatic check_calib_gate();
	int errs;
	int pushed;
	int prev;
	int cycles;
	errs = err_count;
	pushed = 0;
	// k counts rising edges since reset release
	for (int k = 1; k <= CALIB_CYCLES; k++) begin
		@(negedge clk);
		if (calib_done !== (k >= CALIB_CYCLES)) begin
			report_mismatch("calib_done", k >= CALIB_CYCLES, calib_done);
		end
		if (k > 2 * BURST_LEN && in_count !== 2 * BURST_LEN) begin
			report_mismatch("in_count", 2 * BURST_LEN, in_count);
		end
		in_push = (pushed < 2 * BURST_LEN);
		if (in_push) begin
			in_data = $random(seed);
			exp_q.push_back(in_data);
			pushed++;
		end
	end
	@(negedge clk);
	in_push = 1'b0;
	// Level only falls once the bursts start
	prev = in_count;
	cycles = 0;
	while (in_count != 0 && cycles < 400) begin
		@(negedge clk);
		cycles++;
		if (in_count > prev) begin
			report_problem("input level rose while draining");
		end
		if (calib_done !== 1'b1) begin
			report_mismatch("calib_done", 1, calib_done);
		end
		prev = in_count;
	end
	if (in_count != 0) begin
		report_problem("input buffer did not drain after calibration");
	end
	report_test("Calibration gate", errs);
endtask

task automatic hold_partial_burst();
	int errs;
	errs = err_count;
	push_words(BURST_LEN - 3);
	for (int i = 0; i < 100; i++) begin
		@(negedge clk);
		if (in_count !== BURST_LEN - 3) begin
			report_mismatch("in_count", BURST_LEN - 3, in_count);
		end
	end
	// With write mode off the buffer fills and drops one more word
	writes_en = 1'b0;
	push_words(FIFO_DEPTH - BURST_LEN + 3);
	if (in_full !== 1'b1) begin
		report_mismatch("in_full", 1, in_full);
	end
	@(negedge clk);
	in_push = 1'b1;
	in_data = $random(seed);
	@(negedge clk);
	in_push = 1'b0;
	if (in_count !== FIFO_DEPTH) begin
		report_mismatch("in_count", FIFO_DEPTH, in_count);
	end
	writes_en = 1'b1;
	wait_in_empty(400);
	if (in_full !== 1'b0) begin
		report_mismatch("in_full", 0, in_full);
	end
	report_test("Partial burst held", errs);
endtask

task automatic loop_back_one_burst();
	int errs;
	errs = err_count;
	push_words(BURST_LEN);
	wait_in_empty(200);
	read_bursts(1);
	pop_check(BURST_LEN);
	// One more pop finds the buffer empty
	@(negedge clk);
	out_pop = 1'b1;
	@(negedge clk);
	out_pop = 1'b0;
	if (out_valid !== 1'b0) begin
		report_mismatch("out_valid", 0, out_valid);
	end
	report_test("Single-burst loopback", errs);
endtask

task automatic loop_back_four_bursts();
	int errs;
	errs = err_count;
	push_words(4 * BURST_LEN);
	wait_in_empty(400);
	read_bursts(4);
	pop_check(4 * BURST_LEN);
	if (out_count !== 0) begin
		report_mismatch("out_count", 0, out_count);
	end
	report_test("Multi-burst address advance", errs);
endtask

task automatic fill_output_unpopped();
	int errs;
	int peak;
	int level;
	errs = err_count;
	push_words(5 * BURST_LEN);
	wait_in_empty(500);
	// Output level then moves in whole bursts up from empty
	read_bursts(1);
	pop_check(BURST_LEN);
	@(negedge clk);
	reads_en = 1'b1;
	wait_out_level(READ_ROOM + 1, 600);
	peak = out_count;
	for (int i = 0; i < 150; i++) begin
		@(negedge clk);
		if (out_count > peak) begin
			peak = out_count;
		end
	end
	if (peak > READ_ROOM + BURST_LEN) begin
		report_problem($sformatf("output level peaked at %0d words", peak));
	end
	if (peak >= FIFO_DEPTH) begin
		report_problem("output buffer became full");
	end
	reads_en = 1'b0;
	@(negedge clk);
	level = out_count;
	pop_check(level);
	if (out_count !== 0) begin
		report_mismatch("out_count", 0, out_count);
	end
	report_test("Output back-pressure", errs);
endtask

task automatic restart_after_reset();
	int errs;
	int cycles;
	errs = err_count;
	@(negedge clk);
	reset_d = 1'b1;
	repeat (8) @(negedge clk);
	reset_d = 1'b0;
	if (calib_done !== 1'b0) begin
		report_mismatch("calib_done", 0, calib_done);
	end
	if (in_count !== 0) begin
		report_mismatch("in_count", 0, in_count);
	end
	if (out_count !== 0) begin
		report_mismatch("out_count", 0, out_count);
	end
	// Old memory contents no longer count
	exp_q.delete();
	cycles = 0;
	while (calib_done !== 1'b1 && cycles < 4 * CALIB_CYCLES) begin
		@(negedge clk);
		cycles++;
	end
	if (calib_done !== 1'b1) begin
		report_problem("memory did not finish calibration after reset");
	end
	push_words(BURST_LEN);
	wait_in_empty(200);
	read_bursts(1);
	pop_check(BURST_LEN);
	report_test("Reset restarts addresses", errs);
endtask

`endif

/* bench/dma_tb.sv */
`default_nettype none

module dma_tb;
	import dma_pkg::*;

	// Tests take about 2000 cycles
	localparam int TIMEOUT_CYCLES = 6000;
	localparam logic [ADDR_W-1:0] START_ADDR = 30'h0000_0040;

	logic               clk;
	logic               reset_d;
	logic               writes_en;
	logic               reads_en;
	logic [ADDR_W-1:0]  start_addr;
	logic               in_push;
	logic [DATA_W-1:0]  in_data;
	logic               in_full;
	logic [COUNT_W-1:0] in_count;
	logic               out_pop;
	logic [DATA_W-1:0]  out_data;
	logic               out_valid;
	logic [COUNT_W-1:0] out_count;
	logic               calib_done;

	integer             seed;
	int                 err_count;
	int                 pass_count;
	int                 fail_count;
	int                 cycle_count;
	// Written words in memory order, not yet read back
	logic [DATA_W-1:0]  exp_q [$];

	dma_subsystem DUT (
		.clk        (clk),
		.reset_d    (reset_d),
		.writes_en  (writes_en),
		.reads_en   (reads_en),
		.start_addr (start_addr),
		.in_push    (in_push),
		.in_data    (in_data),
		.in_full    (in_full),
		.in_count   (in_count),
		.out_pop    (out_pop),
		.out_data   (out_data),
		.out_valid  (out_valid),
		.out_count  (out_count),
		.calib_done (calib_done)
	);

	`include "dma_tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run stopped after %0d cycles before the tests finished", cycle_count);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed = 32'h6c9f_81e5;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		reset_d = 1'b1;
		writes_en = 1'b1;
		reads_en = 1'b0;
		start_addr = START_ADDR;
		in_push = 1'b0;
		in_data = '0;
		out_pop = 1'b0;

		repeat (8) @(negedge clk);
		reset_d = 1'b0;

		// Calibration window starts at this release
		check_calib_gate();
		hold_partial_burst();
		loop_back_one_burst();
		loop_back_four_bursts();
		fill_output_unpopped();
		restart_after_reset();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/ddr_user_port.sv */
`default_nettype none

module ddr_user_port (
	input  wire                          clk,
	input  wire                          reset_d,
	output logic                         calib_done,
	// Command queue
	input  wire                          cmd_en,
	input  wire  [dma_pkg::CMD_W-1:0]    cmd_instr,
	input  wire  [dma_pkg::ADDR_W-1:0]   cmd_byte_addr,
	output logic                         cmd_full,
	// Write-data queue
	input  wire                          wr_en,
	input  wire  [dma_pkg::DATA_W-1:0]   wr_data,
	output logic                         wr_full,
	// Read-data queue
	input  wire                          rd_en,
	output logic                         rd_empty,
	output logic [dma_pkg::DATA_W-1:0]   rd_data
);
	import dma_pkg::*;

	logic [$clog2(CALIB_CYCLES+1)-1:0]    calib_cnt;

	logic [CMD_W-1:0]                     cq_instr [CMD_QUEUE_DEPTH];
	logic [ADDR_W-1:0]                    cq_addr [CMD_QUEUE_DEPTH];
	logic [$clog2(CMD_QUEUE_DEPTH)-1:0]   cq_wr_ptr;
	logic [$clog2(CMD_QUEUE_DEPTH)-1:0]   cq_rd_ptr;
	logic [$clog2(CMD_QUEUE_DEPTH+1)-1:0] cq_count;
	logic                                 cq_push;
	logic                                 cq_pop;

	logic [DATA_W-1:0]                    wq_mem [WQ_DEPTH];
	logic [$clog2(WQ_DEPTH)-1:0]          wq_wr_ptr;
	logic [$clog2(WQ_DEPTH)-1:0]          wq_rd_ptr;
	logic [$clog2(WQ_DEPTH+1)-1:0]        wq_count;
	logic                                 wq_push;
	logic                                 wq_pop;

	logic [DATA_W-1:0]                    rq_mem [RQ_DEPTH];
	logic [$clog2(RQ_DEPTH)-1:0]          rq_wr_ptr;
	logic [$clog2(RQ_DEPTH)-1:0]          rq_rd_ptr;
	logic [$clog2(RQ_DEPTH+1)-1:0]        rq_count;
	logic                                 rq_push;
	logic                                 rq_pop;

	logic [DATA_W-1:0]                    mem [MEM_WORDS];
	logic                                 exec_busy;
	logic                                 exec_is_read;
	logic [$clog2(MEM_WORDS)-1:0]         exec_idx;
	logic [BURST_CNT_W-1:0]               exec_beat;
	logic                                 exec_step;

	assign cmd_full = (cq_count == CMD_QUEUE_DEPTH);
	assign wr_full = (wq_count == WQ_DEPTH);
	assign rd_empty = (rq_count == 0);

	assign cq_push = cmd_en && !cmd_full;
	assign wq_push = wr_en && !wr_full;
	assign rq_pop = rd_en && !rd_empty;

	// Executor takes the next command when idle
	assign cq_pop = calib_done && !exec_busy && (cq_count != 0);
	// Write beats wait for data, read beats wait for queue space
	assign wq_pop = exec_busy && !exec_is_read && (wq_count != 0);
	assign rq_push = exec_busy && exec_is_read && (rq_count != RQ_DEPTH);
	assign exec_step = wq_pop || rq_push;

	// Calibration
	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			calib_cnt <= '0;
			calib_done <= 1'b0;
		end else if (!calib_done) begin
			calib_cnt <= calib_cnt + 1'b1;
			calib_done <= (calib_cnt == CALIB_CYCLES - 1);
		end
	end

	// Queue and memory storage
	always_ff @(posedge clk) begin
		if (cq_push) begin
			cq_instr[cq_wr_ptr] <= cmd_instr;
			cq_addr[cq_wr_ptr] <= cmd_byte_addr;
		end
		if (wq_push) begin
			wq_mem[wq_wr_ptr] <= wr_data;
		end
		if (wq_pop) begin
			mem[exec_idx] <= wq_mem[wq_rd_ptr];
		end
		if (rq_push) begin
			rq_mem[rq_wr_ptr] <= mem[exec_idx];
		end
		if (rq_pop) begin
			rd_data <= rq_mem[rq_rd_ptr];
		end
	end

	// Queue pointers and levels
	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			cq_wr_ptr <= '0;
			cq_rd_ptr <= '0;
			cq_count <= '0;
			wq_wr_ptr <= '0;
			wq_rd_ptr <= '0;
			wq_count <= '0;
			rq_wr_ptr <= '0;
			rq_rd_ptr <= '0;
			rq_count <= '0;
		end else begin
			cq_wr_ptr <= cq_wr_ptr + cq_push;
			cq_rd_ptr <= cq_rd_ptr + cq_pop;
			cq_count <= cq_count + cq_push - cq_pop;
			wq_wr_ptr <= wq_wr_ptr + wq_push;
			wq_rd_ptr <= wq_rd_ptr + wq_pop;
			wq_count <= wq_count + wq_push - wq_pop;
			rq_wr_ptr <= rq_wr_ptr + rq_push;
			rq_rd_ptr <= rq_rd_ptr + rq_pop;
			rq_count <= rq_count + rq_push - rq_pop;
		end
	end

	// One command at a time, one word per beat
	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			exec_busy <= 1'b0;
			exec_is_read <= 1'b0;
			exec_idx <= '0;
			exec_beat <= '0;
		end else if (cq_pop) begin
			exec_busy <= 1'b1;
			exec_is_read <= (cq_instr[cq_rd_ptr] == CMD_READ);
			// Word index is the byte address over four, wrapped to the array
			exec_idx <= cq_addr[cq_rd_ptr][2 +: $clog2(MEM_WORDS)];
			exec_beat <= '0;
		end else if (exec_step) begin
			exec_idx <= exec_idx + 1'b1;
			exec_beat <= exec_beat + 1'b1;
			if (exec_beat == BURST_LEN - 1) begin
				exec_busy <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* design/dma.sv */
`default_nettype none

module dma (
	input  wire                          clk,
	input  wire                          reset_d,
	input  wire                          writes_en,
	input  wire                          reads_en,
	input  wire  [dma_pkg::ADDR_W-1:0]   start_addr,
	input  wire                          calib_done,
	// Input buffer
	output logic                         ib_re,
	input  wire  [dma_pkg::DATA_W-1:0]   ib_data,
	input  wire  [dma_pkg::COUNT_W-1:0]  ib_count,
	input  wire                          ib_valid,
	// Output buffer
	output logic                         ob_we,
	output logic [dma_pkg::DATA_W-1:0]   ob_data,
	input  wire  [dma_pkg::COUNT_W-1:0]  ob_count,
	// Memory command port
	input  wire                          cmd_full,
	output logic                         cmd_en,
	output logic [dma_pkg::CMD_W-1:0]    cmd_instr,
	output logic [dma_pkg::ADDR_W-1:0]   cmd_byte_addr,
	// Memory write data
	input  wire                          wr_full,
	output logic                         wr_en,
	output logic [dma_pkg::DATA_W-1:0]   wr_data,
	// Memory read data
	input  wire                          rd_empty,
	input  wire  [dma_pkg::DATA_W-1:0]   rd_data,
	output logic                         rd_en
);
	import dma_pkg::*;

	enum logic [2:0] {
		ST_IDLE,
		ST_WR_REQ,
		ST_WR_WAIT,
		ST_WR_CNT,
		ST_RD_CMD,
		ST_RD_WAIT,
		ST_RD_POP,
		ST_RD_STORE
	} state, state_nxt;

	logic                   write_mode;
	logic                   read_mode;
	logic [BURST_CNT_W-1:0] burst_cnt;
	logic [ADDR_W-1:0]      wr_addr;
	logic [ADDR_W-1:0]      rd_addr;
	logic                   start_write;
	logic                   start_read;

	// A full burst waiting on the input side
	assign start_write = calib_done && write_mode && (ib_count >= BURST_LEN) && !cmd_full;
	// Room for a whole burst on the output side after the last store lands
	assign start_read = calib_done && read_mode && !ob_we &&
		(ob_count <= READ_ROOM) && !cmd_full;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				// Writes win when both could start
				if (start_write) begin
					state_nxt = ST_WR_REQ;
				end else if (start_read) begin
					state_nxt = ST_RD_CMD;
				end
			end
			ST_WR_REQ: begin
				if (!wr_full) begin
					state_nxt = ST_WR_WAIT;
				end
			end
			ST_WR_WAIT: begin
				if (ib_valid) begin
					state_nxt = ST_WR_CNT;
				end
			end
			ST_WR_CNT: state_nxt = (burst_cnt == 0) ? ST_IDLE : ST_WR_REQ;
			ST_RD_CMD: state_nxt = ST_RD_WAIT;
			ST_RD_WAIT: begin
				if (!rd_empty) begin
					state_nxt = ST_RD_POP;
				end
			end
			ST_RD_POP: state_nxt = ST_RD_STORE;
			ST_RD_STORE: state_nxt = (burst_cnt == 0) ? ST_IDLE : ST_RD_WAIT;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			state <= ST_IDLE;
			write_mode <= 1'b0;
			read_mode <= 1'b0;
			burst_cnt <= '0;
			wr_addr <= start_addr;
			rd_addr <= start_addr;
			cmd_en <= 1'b0;
			cmd_instr <= CMD_WRITE;
			cmd_byte_addr <= '0;
			wr_en <= 1'b0;
			ib_re <= 1'b0;
			rd_en <= 1'b0;
			ob_we <= 1'b0;
		end else begin
			state <= state_nxt;
			write_mode <= writes_en;
			read_mode <= reads_en;
			// Strobes last one cycle unless a state raises them
			cmd_en <= 1'b0;
			wr_en <= 1'b0;
			ib_re <= 1'b0;
			rd_en <= 1'b0;
			ob_we <= 1'b0;
			case (state)
				ST_IDLE: burst_cnt <= BURST_CNT_W'(BURST_LEN);
				ST_WR_REQ: ib_re <= !wr_full;
				ST_WR_WAIT: begin
					if (ib_valid) begin
						wr_en <= 1'b1;
						burst_cnt <= burst_cnt - 1'b1;
					end
				end
				ST_WR_CNT: begin
					// Command goes out once all its words are queued
					if (burst_cnt == 0) begin
						cmd_en <= 1'b1;
						cmd_instr <= CMD_WRITE;
						cmd_byte_addr <= wr_addr;
						wr_addr <= wr_addr + ADDR_W'(4 * BURST_LEN);
					end
				end
				ST_RD_CMD: begin
					cmd_en <= 1'b1;
					cmd_instr <= CMD_READ;
					cmd_byte_addr <= rd_addr;
					rd_addr <= rd_addr + ADDR_W'(4 * BURST_LEN);
				end
				ST_RD_WAIT: rd_en <= !rd_empty;
				ST_RD_POP: burst_cnt <= burst_cnt - 1'b1;
				ST_RD_STORE: ob_we <= 1'b1;
				default: ;
			endcase
		end
	end

	// Data words follow their strobes
	always_ff @(posedge clk) begin
		if (state == ST_WR_WAIT && ib_valid) begin
			wr_data <= ib_data;
		end
		// rd_data holds the word popped in the previous cycle
		if (state == ST_RD_STORE) begin
			ob_data <= rd_data;
		end
	end

endmodule

`default_nettype wire

/* design/dma_pkg.sv */
`default_nettype none

package dma_pkg;

	// User port word and byte address
	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;

	// Words per memory command
	localparam int BURST_LEN = 8;
	localparam int BURST_CNT_W = $clog2(BURST_LEN + 1);

	// Host-side buffers
	localparam int FIFO_DEPTH = 64;
	localparam int COUNT_W = 7;
	// Highest output level that still leaves room for one more burst
	localparam int READ_ROOM = FIFO_DEPTH - 1 - BURST_LEN;

	// Memory command codes
	localparam int CMD_W = 3;
	localparam logic [CMD_W-1:0] CMD_WRITE = 3'd0;
	localparam logic [CMD_W-1:0] CMD_READ = 3'd1;

	// Behavioral memory model
	localparam int MEM_WORDS = 256;
	localparam int CALIB_CYCLES = 20;
	localparam int CMD_QUEUE_DEPTH = 4;
	localparam int WQ_DEPTH = 16;
	localparam int RQ_DEPTH = 16;

endpackage

`default_nettype wire

/* design/dma_subsystem.sv */
`default_nettype none

module dma_subsystem (
	input  wire                          clk,
	input  wire                          reset_d,
	input  wire                          writes_en,
	input  wire                          reads_en,
	input  wire  [dma_pkg::ADDR_W-1:0]   start_addr,
	// Host write side
	input  wire                          in_push,
	input  wire  [dma_pkg::DATA_W-1:0]   in_data,
	output logic                         in_full,
	output logic [dma_pkg::COUNT_W-1:0]  in_count,
	// Host read side
	input  wire                          out_pop,
	output logic [dma_pkg::DATA_W-1:0]   out_data,
	output logic                         out_valid,
	output logic [dma_pkg::COUNT_W-1:0]  out_count,
	output logic                         calib_done
);
	import dma_pkg::*;

	logic              ib_re;
	logic [DATA_W-1:0] ib_data;
	logic              ib_valid;
	logic              ob_we;
	logic [DATA_W-1:0] ob_data;
	logic              cmd_en;
	logic [CMD_W-1:0]  cmd_instr;
	logic [ADDR_W-1:0] cmd_byte_addr;
	logic              cmd_full;
	logic              wr_en;
	logic [DATA_W-1:0] wr_data;
	logic              wr_full;
	logic              rd_en;
	logic              rd_empty;
	logic [DATA_W-1:0] rd_data;

	// Words from the host waiting for a write burst
	sync_fifo u_in_buf (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (in_push),
		.push_data (in_data),
		.pop       (ib_re),
		.pop_data  (ib_data),
		.pop_valid (ib_valid),
		.count     (in_count),
		.full      (in_full)
	);

	// Words read back from memory for the host
	sync_fifo u_out_buf (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (ob_we),
		.push_data (ob_data),
		.pop       (out_pop),
		.pop_data  (out_data),
		.pop_valid (out_valid),
		.count     (out_count),
		.full      ()
	);

	dma u_dma (
		.clk           (clk),
		.reset_d       (reset_d),
		.writes_en     (writes_en),
		.reads_en      (reads_en),
		.start_addr    (start_addr),
		.calib_done    (calib_done),
		.ib_re         (ib_re),
		.ib_data       (ib_data),
		.ib_count      (in_count),
		.ib_valid      (ib_valid),
		.ob_we         (ob_we),
		.ob_data       (ob_data),
		.ob_count      (out_count),
		.cmd_full      (cmd_full),
		.cmd_en        (cmd_en),
		.cmd_instr     (cmd_instr),
		.cmd_byte_addr (cmd_byte_addr),
		.wr_full       (wr_full),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.rd_empty      (rd_empty),
		.rd_data       (rd_data),
		.rd_en         (rd_en)
	);

	ddr_user_port u_ddr (
		.clk           (clk),
		.reset_d       (reset_d),
		.calib_done    (calib_done),
		.cmd_en        (cmd_en),
		.cmd_instr     (cmd_instr),
		.cmd_byte_addr (cmd_byte_addr),
		.cmd_full      (cmd_full),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.wr_full       (wr_full),
		.rd_en         (rd_en),
		.rd_empty      (rd_empty),
		.rd_data       (rd_data)
	);

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
`default_nettype none

module sync_fifo (
	input  wire                          clk,
	input  wire                          reset_d,
	input  wire                          push,
	input  wire  [dma_pkg::DATA_W-1:0]   push_data,
	input  wire                          pop,
	output logic [dma_pkg::DATA_W-1:0]   pop_data,
	output logic                         pop_valid,
	output logic [dma_pkg::COUNT_W-1:0]  count,
	output logic                         full
);
	import dma_pkg::*;

	logic [DATA_W-1:0]             mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic                          do_push;
	logic                          do_pop;

	assign full = (count == FIFO_DEPTH);

	// Pushes into a full buffer are dropped
	assign do_push = push && !full;
	// Pops of an empty buffer give no valid
	assign do_pop = pop && (count != 0);

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Registered read word
	always_ff @(posedge clk) begin
		if (do_pop) begin
			pop_data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			pop_valid <= 1'b0;
			count <= '0;
		end else begin
			pop_valid <= do_pop;
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Fill level follows both ends in the same cycle
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+bench
design/dma_pkg.sv
design/sync_fifo.sv
design/dma.sv
design/ddr_user_port.sv
design/dma_subsystem.sv
bench/dma_tb.sv
